// ==== avalon_rdwr_mem.f ====
+incdir+hdl
hdl/avalon_mem_pkg.sv
hdl/mem_ctrl_pkg.sv
hdl/avalon_mem_rdwr_if.sv
hdl/avalon_mem_rdwr_connect.sv
hdl/avalon_burst_memory.sv
hdl/avalon_rdwr_mem_top.sv
verification/avalon_rdwr_mem_chk.sv
verification/avalon_rdwr_mem_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory endpoint testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f avalon_rdwr_mem.f \
		--top-module avalon_rdwr_mem_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vavalon_rdwr_mem_tb > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/avalon_rdwr_mem_patterns.txt ====
# op (0 write, 1 read, 2 idle) addr burst wdata byteenable expected
# all hex; expected is the first beat of a read, checked against the model
1 05 1 00000000 0 00000000
0 00 1 11223344 f 00000000
1 00 1 00000000 0 11223344
0 00 1 aabbccdd 5 00000000
1 00 1 00000000 0 11bb33dd
0 3e 1 a0a0a0a0 f 00000000
0 3f 1 b1b1b1b1 f 00000000
0 01 1 c2c2c2c2 f 00000000
1 3e 4 00000000 0 a0a0a0a0
1 3f 2 00000000 0 b1b1b1b1
2 00 0 00000000 0 00000000
0 10 1 deadbeef f 00000000
1 10 1 00000000 0 deadbeef
0 10 1 00000077 1 00000000
1 10 3 00000000 0 deadbe77

// ==== verification/avalon_rdwr_mem_tb.sv ====
//////////////////////////////////////////////////
// Testbench of the memory endpoint top level
// Replays the pattern file, checks every read beat
// against a reference model and ends on a watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "avalon_mem_macros.svh"

module avalon_rdwr_mem_tb;
    import avalon_mem_pkg::*;
    import mem_ctrl_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int WORDS = 1 << `AVMM_ADDR_WIDTH;

    logic        clk;
    logic        reset;
    logic        rd_read;
    address_t    rd_address;
    burstcount_t rd_burstcount;
    logic        rd_waitrequest;
    data_t       rd_readdata;
    logic        rd_readdatavalid;
    logic        wr_write;
    address_t    wr_address;
    data_t       wr_writedata;
    byteenable_t wr_byteenable;
    logic        wr_waitrequest;

    // Pattern columns, one entry per command line
    mem_cmd_t    pat_op [$];
    address_t    pat_addr [$];
    burstcount_t pat_burst [$];
    data_t       pat_wdata [$];
    byteenable_t pat_be [$];
    data_t       pat_exp [$];

    data_t model [WORDS];
    data_t exp_q [$];
    data_t exp_word;
    logic  loaded;

    avalon_rdwr_mem_top avalon_rdwr_mem_top_i
    (
        .clk              (clk),
        .reset            (reset),
        .rd_read          (rd_read),
        .rd_address       (rd_address),
        .rd_burstcount    (rd_burstcount),
        .rd_waitrequest   (rd_waitrequest),
        .rd_readdata      (rd_readdata),
        .rd_readdatavalid (rd_readdatavalid),
        .wr_write         (wr_write),
        .wr_address       (wr_address),
        .wr_writedata     (wr_writedata),
        .wr_byteenable    (wr_byteenable),
        .wr_waitrequest   (wr_waitrequest)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Reads every non-comment line of the pattern file into the queues
    task automatic load_patterns();
        int    fd;
        int    fields;
        string line;
        logic [31:0] op_v, addr_v, burst_v, wdata_v, be_v, exp_v;
        fd = $fopen("verification/avalon_rdwr_mem_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the pattern file");
            $display("Testbench failed");
            $fatal(1);
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%h %h %h %h %h %h",
                    op_v, addr_v, burst_v, wdata_v, be_v, exp_v);
                if (fields == 6)
                begin
                    pat_op.push_back(mem_cmd_t'(op_v[1:0]));
                    pat_addr.push_back(address_t'(addr_v));
                    pat_burst.push_back(burstcount_t'(burst_v));
                    pat_wdata.push_back(data_t'(wdata_v));
                    pat_be.push_back(byteenable_t'(be_v));
                    pat_exp.push_back(data_t'(exp_v));
                end
            end
        end
        $fclose(fd);
    endtask

    // One idle cycle with both strobes low
    task automatic drive_idle();
        @(negedge clk);
        rd_read  = 1'b0;
        wr_write = 1'b0;
    endtask

    // Presents a command on the falling edge and holds it until accepted
    task automatic issue_command(input int idx);
        @(negedge clk);
        rd_read  = (pat_op[idx] == CMD_READ);
        wr_write = (pat_op[idx] == CMD_WRITE);
        rd_address    = pat_addr[idx];
        rd_burstcount = pat_burst[idx];
        wr_address    = pat_addr[idx];
        wr_writedata  = pat_wdata[idx];
        wr_byteenable = pat_be[idx];
        #1;
        while ((rd_read && rd_waitrequest) || (wr_write && wr_waitrequest))
        begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    // Updates the model for a write, or queues the words a read must return
    task automatic model_command(input int idx);
        address_t a;
        a = pat_addr[idx];
        if (pat_op[idx] == CMD_WRITE)
        begin
            for (int b = 0; b < `AVMM_DATA_WIDTH / 8; b++)
            begin
                if (pat_be[idx][b])
                begin
                    model[a][b*8 +: 8] = pat_wdata[idx][b*8 +: 8];
                end
            end
        end
        else if (pat_op[idx] == CMD_READ)
        begin
            assert (pat_exp[idx] == model[a])
            else
            begin
                $display("Mismatch pattern expected %h model %h", pat_exp[idx], model[a]);
                $display("Testbench failed");
                $fatal(1);
            end
            for (int k = 0; k < int'(pat_burst[idx]); k++)
            begin
                exp_q.push_back(model[a]);
                a = a + address_t'(1);
            end
        end
    endtask

    // Read beats are stable on the falling edge
    always @(negedge clk)
    begin
        if (!reset && rd_readdatavalid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("A read beat arrived with no read outstanding");
                $display("Testbench failed");
                $fatal(1);
            end
            exp_word = exp_q.pop_front();
            assert (rd_readdata == exp_word)
            else
            begin
                $display("Mismatch rd_readdata expected %h actual %h", exp_word, rd_readdata);
                $display("Testbench failed");
                $fatal(1);
            end
        end
    end

    // Each command gets its handshake, four beats and three idle cycles
    initial
    begin
        wait (loaded);
        #(longint'(pat_op.size()) * 11 * CLK_PERIOD + 40 * CLK_PERIOD);
        $display("Reads did not complete before the watchdog expired");
        $display("Testbench failed");
        $fatal(1);
    end

    initial
    begin
        reset = 1'b1;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_writedata = '0;
        wr_byteenable = '0;
        loaded = 1'b0;
        void'($urandom(81));
        for (int i = 0; i < WORDS; i++)
        begin
            model[i] = '0;
        end
        load_patterns();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < pat_op.size(); i++)
        begin
            // A write waits for earlier reads so the model stays in order
            if (pat_op[i] == CMD_WRITE)
            begin
                while (exp_q.size() != 0)
                begin
                    drive_idle();
                end
            end
            model_command(i);
            if (pat_op[i] == CMD_IDLE)
            begin
                drive_idle();
            end
            else
            begin
                issue_command(i);
            end
            // Writes run straight into the next command
            if (pat_op[i] != CMD_WRITE)
            begin
                repeat ($urandom_range(3, 0)) drive_idle();
            end
        end
        drive_idle();
        while (exp_q.size() != 0)
        begin
            drive_idle();
        end
        repeat (4) drive_idle();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verification/avalon_rdwr_mem_chk.sv ====
//////////////////////////////////////////////////
// Protocol checks on the host ports of the top
// Bound into the top level to watch the host bus
//////////////////////////////////////////////////

`timescale 1ns/1ps

module avalon_rdwr_mem_chk
(
    input logic                        clk,
    input logic                        reset,
    input logic                        rd_read,
    input avalon_mem_pkg::address_t    rd_address,
    input avalon_mem_pkg::burstcount_t rd_burstcount,
    input logic                        rd_waitrequest,
    input logic                        rd_readdatavalid,
    input logic                        wr_waitrequest
);
    import avalon_mem_pkg::*;

    // Beats still owed to the host by accepted reads
    logic [4:0] pending;
    logic       rd_accept;

    assign rd_accept = rd_read && !rd_waitrequest;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= '0;
        end
        else
        begin
            pending <= pending + (rd_accept ? 5'(rd_burstcount) : 5'd0)
                - (rd_readdatavalid ? 5'd1 : 5'd0);
        end
    end

    // A stalled read must not change before it is taken
    rd_stable: assert property (@(posedge clk) disable iff (reset)
        rd_read && rd_waitrequest |=> rd_read && $stable(rd_address)
            && $stable(rd_burstcount))
        else $error("read request changed while stalled");

    // No beat may show up unless a read is still owed data
    beat_owed: assert property (@(posedge clk) disable iff (reset)
        rd_readdatavalid |-> pending != 5'd0)
        else $error("read beat with no outstanding read");

    // The write channel never stalls, so write requests need no hold rule
    wr_never_stalls: assert property (@(posedge clk) disable iff (reset)
        !wr_waitrequest)
        else $error("write channel stalled");

endmodule

bind avalon_rdwr_mem_top avalon_rdwr_mem_chk avalon_rdwr_mem_chk_i
(
    .clk              (clk),
    .reset            (reset),
    .rd_read          (rd_read),
    .rd_address       (rd_address),
    .rd_burstcount    (rd_burstcount),
    .rd_waitrequest   (rd_waitrequest),
    .rd_readdatavalid (rd_readdatavalid),
    .wr_waitrequest   (wr_waitrequest)
);

// ==== hdl/avalon_rdwr_mem_top.sv ====
//////////////////////////////////////////////////
// Memory endpoint top level
// Host ports feed a request slice and then the
// burst memory over two split bus instances
//////////////////////////////////////////////////

`timescale 1ns/1ps

module avalon_rdwr_mem_top
(
    input  logic clk,
    input  logic reset,

    // Read channel from the host
    input  logic                       rd_read,
    input  avalon_mem_pkg::address_t    rd_address,
    input  avalon_mem_pkg::burstcount_t rd_burstcount,
    output logic                       rd_waitrequest,
    output avalon_mem_pkg::data_t       rd_readdata,
    output logic                       rd_readdatavalid,

    // Write channel from the host
    input  logic                       wr_write,
    input  avalon_mem_pkg::address_t    wr_address,
    input  avalon_mem_pkg::data_t       wr_writedata,
    input  avalon_mem_pkg::byteenable_t wr_byteenable,
    output logic                       wr_waitrequest
);

    // Host side of the connector
    avalon_mem_rdwr_if host_bus ();
    // Memory side of the connector
    avalon_mem_rdwr_if mem_bus ();

    assign host_bus.rd_read       = rd_read;
    assign host_bus.rd_address    = rd_address;
    assign host_bus.rd_burstcount = rd_burstcount;
    assign host_bus.wr_write      = wr_write;
    assign host_bus.wr_address    = wr_address;
    assign host_bus.wr_writedata  = wr_writedata;
    assign host_bus.wr_byteenable = wr_byteenable;

    assign rd_waitrequest   = host_bus.rd_waitrequest;
    assign rd_readdata      = host_bus.rd_readdata;
    assign rd_readdatavalid = host_bus.rd_readdatavalid;
    assign wr_waitrequest   = host_bus.wr_waitrequest;

    avalon_mem_rdwr_connect avalon_mem_rdwr_connect_i
    (
        .clk        (clk),
        .reset      (reset),
        .mem_slave  (mem_bus.to_slave),
        .mem_master (host_bus.to_master)
    );

    avalon_burst_memory avalon_burst_memory_i
    (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.to_master)
    );

endmodule

// ==== hdl/avalon_burst_memory.sv ====
//////////////////////////////////////////////////
// 64-word memory slave on the split bus
// Takes byte-enabled single writes every cycle and
// serves one read burst at a time
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "avalon_mem_macros.svh"

module avalon_burst_memory
(
    input  logic clk,
    input  logic reset,

    avalon_mem_rdwr_if.to_master mem
);
    import avalon_mem_pkg::*;
    import mem_ctrl_pkg::*;

    data_t mem_array [1 << `AVMM_ADDR_WIDTH];

    rd_state_t rd_state;
    logic [`AVMM_RD_LAT_WIDTH-1:0] lat_cnt;
    burstcount_t beats_left;
    address_t rd_addr;
    data_t rd_data_q;
    logic rd_valid_q;

    mem_cmd_t wr_cmd;
    mem_cmd_t rd_cmd;
    logic rd_busy;
    logic beat_emit;
    logic last_beat;

    // Busy from the accept until the last beat goes out
    assign rd_busy = (rd_state != RD_IDLE);

    // Request decode, one command per channel
    // Writes are never stalled, so every write strobe is a write command
    assign wr_cmd = mem.wr_write ? CMD_WRITE : CMD_IDLE;
    assign rd_cmd = (mem.rd_read && !rd_busy) ? CMD_READ : CMD_IDLE;

    // A beat leaves once the latency count has run out and on every
    // cycle of the burst after that
    assign beat_emit = ((rd_state == RD_WAIT) && (lat_cnt == '0)) || (rd_state == RD_BURST);
    assign last_beat = (beats_left <= burstcount_t'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_state   <= RD_IDLE;
            lat_cnt    <= '0;
            beats_left <= '0;
            rd_valid_q <= 1'b0;
            // Contents start out as zero
            for (int i = 0; i < (1 << `AVMM_ADDR_WIDTH); i++)
            begin
                mem_array[i] <= '0;
            end
        end
        else
        begin
            if (wr_cmd == CMD_WRITE)
            begin
                for (int b = 0; b < `AVMM_DATA_WIDTH / 8; b++)
                begin
                    if (mem.wr_byteenable[b])
                    begin
                        mem_array[mem.wr_address][b*8 +: 8] <= mem.wr_writedata[b*8 +: 8];
                    end
                end
            end

            rd_valid_q <= beat_emit;
            if (beat_emit)
            begin
                beats_left <= beats_left - burstcount_t'(1);
            end

            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_cmd == CMD_READ)
                    begin
                        rd_state   <= RD_WAIT;
                        lat_cnt    <= `AVMM_RD_LAT_WIDTH'(`AVMM_RD_LATENCY - 1);
                        beats_left <= mem.rd_burstcount;
                    end
                end
                RD_WAIT:
                begin
                    if (lat_cnt != '0)
                    begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                    else
                    begin
                        // The first beat goes out here
                        rd_state <= last_beat ? RD_IDLE : RD_BURST;
                    end
                end
                RD_BURST:
                begin
                    if (last_beat)
                    begin
                        rd_state <= RD_IDLE;
                    end
                end
                default:
                begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // Read address and data path
    // The address wraps from 63 to 0 by its width
    always_ff @(posedge clk)
    begin
        if (rd_cmd == CMD_READ)
        begin
            rd_addr <= mem.rd_address;
        end
        else if (beat_emit)
        begin
            rd_addr <= rd_addr + address_t'(1);
        end

        if (beat_emit)
        begin
            rd_data_q <= mem_array[rd_addr];
        end
    end

    assign mem.rd_waitrequest   = rd_busy;
    assign mem.rd_readdata      = rd_data_q;
    assign mem.rd_readdatavalid = rd_valid_q;
    assign mem.wr_waitrequest   = 1'b0;

endmodule

// ==== hdl/avalon_mem_rdwr_connect.sv ====
//////////////////////////////////////////////////
// Connects two split bus instances through a
// one-entry request slice on each channel
// Responses go straight back with no delay
//////////////////////////////////////////////////

`timescale 1ns/1ps

module avalon_mem_rdwr_connect
(
    input  logic clk,
    input  logic reset,

    avalon_mem_rdwr_if.to_slave  mem_slave,
    avalon_mem_rdwr_if.to_master mem_master
);
    import avalon_mem_pkg::*;

    // Read slice contents
    logic        rd_valid;
    address_t    rd_address_q;
    burstcount_t rd_burstcount_q;

    // Write slice contents
    logic        wr_valid;
    address_t    wr_address_q;
    data_t       wr_writedata_q;
    byteenable_t wr_byteenable_q;

    // Upstream stalls only when the slice is full and the held request
    // is not leaving this cycle, so back-to-back requests flow at full rate
    assign mem_master.rd_waitrequest = rd_valid && mem_slave.rd_waitrequest;
    assign mem_master.wr_waitrequest = wr_valid && mem_slave.wr_waitrequest;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid <= 1'b0;
        end
        else if (mem_master.rd_read && !mem_master.rd_waitrequest)
        begin
            // A new request refills the slice, even as the old one leaves
            rd_valid        <= 1'b1;
            rd_address_q    <= mem_master.rd_address;
            rd_burstcount_q <= mem_master.rd_burstcount;
        end
        else if (rd_valid && !mem_slave.rd_waitrequest)
        begin
            rd_valid <= 1'b0;
        end
    end

    // Same slice on the write channel, with the write payload
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_valid <= 1'b0;
        end
        else if (mem_master.wr_write && !mem_master.wr_waitrequest)
        begin
            wr_valid        <= 1'b1;
            wr_address_q    <= mem_master.wr_address;
            wr_writedata_q  <= mem_master.wr_writedata;
            wr_byteenable_q <= mem_master.wr_byteenable;
        end
        else if (wr_valid && !mem_slave.wr_waitrequest)
        begin
            wr_valid <= 1'b0;
        end
    end

    // Downstream requests come only from the held registers
    assign mem_slave.rd_read       = rd_valid;
    assign mem_slave.rd_address    = rd_address_q;
    assign mem_slave.rd_burstcount = rd_burstcount_q;

    assign mem_slave.wr_write      = wr_valid;
    assign mem_slave.wr_address    = wr_address_q;
    assign mem_slave.wr_writedata  = wr_writedata_q;
    assign mem_slave.wr_byteenable = wr_byteenable_q;

    // Read beats pass back in the same cycle
    assign mem_master.rd_readdata      = mem_slave.rd_readdata;
    assign mem_master.rd_readdatavalid = mem_slave.rd_readdatavalid;

endmodule

// ==== hdl/avalon_mem_rdwr_if.sv ====
//////////////////////////////////////////////////
// Avalon-style split read/write memory bus
// The master side binds to_slave and the slave
// side binds to_master
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface avalon_mem_rdwr_if;
    import avalon_mem_pkg::*;

    // Read request, held by the master while rd_waitrequest is high
    logic        rd_read;
    address_t    rd_address;
    burstcount_t rd_burstcount;
    logic        rd_waitrequest;

    // Read response beats, which cannot be back-pressured
    data_t       rd_readdata;
    logic        rd_readdatavalid;

    // Write request, single beat only and with no response
    logic        wr_write;
    address_t    wr_address;
    data_t       wr_writedata;
    byteenable_t wr_byteenable;
    logic        wr_waitrequest;

    // Used by a master that sends requests toward a slave
    modport to_slave
    (
        output rd_read, rd_address, rd_burstcount,
        input  rd_waitrequest, rd_readdata, rd_readdatavalid,

        output wr_write, wr_address, wr_writedata, wr_byteenable,
        input  wr_waitrequest
    );

    // Used by a slave that answers requests from a master
    modport to_master
    (
        input  rd_read, rd_address, rd_burstcount,
        output rd_waitrequest, rd_readdata, rd_readdatavalid,

        input  wr_write, wr_address, wr_writedata, wr_byteenable,
        output wr_waitrequest
    );

endinterface

// ==== hdl/mem_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// Control encodings of the memory endpoint
// Holds the read FSM states and the command opcodes
//////////////////////////////////////////////////

package mem_ctrl_pkg;

    // Read FSM of the memory slave
    // RD_WAIT counts out the read latency and RD_BURST sends the beats
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_BURST
    } rd_state_t;

    // Command decoded from the bus strobes
    // The pattern file uses the same encoding
    typedef enum logic [1:0] {
        CMD_WRITE,
        CMD_READ,
        CMD_IDLE
    } mem_cmd_t;

endpackage

// ==== hdl/avalon_mem_pkg.sv ====
//////////////////////////////////////////////////
// Field types of the split read/write memory bus
// Import it wherever bus fields are stored or passed
//////////////////////////////////////////////////

`include "avalon_mem_macros.svh"

package avalon_mem_pkg;

    // Word address into the memory
    typedef logic [`AVMM_ADDR_WIDTH-1:0] address_t;

    // One data word on either channel
    typedef logic [`AVMM_DATA_WIDTH-1:0] data_t;

    // One enable bit per data byte
    typedef logic [`AVMM_DATA_WIDTH/8-1:0] byteenable_t;

    // Beat count of a read burst
    // Zero is not a legal value on the bus
    typedef logic [`AVMM_BURST_WIDTH-1:0] burstcount_t;

endpackage

// ==== hdl/avalon_mem_macros.svh ====
//////////////////////////////////////////////////
// Fixed widths and read latency of the split bus
// Include this header wherever a width is needed
//////////////////////////////////////////////////

`ifndef AVALON_MEM_MACROS_SVH
`define AVALON_MEM_MACROS_SVH

// Word address width, so the memory holds 64 words
`define AVMM_ADDR_WIDTH 6
`define AVMM_DATA_WIDTH 32
// Bursts of 1 to 4 beats are legal
`define AVMM_BURST_WIDTH 3
// Cycles from read accept at the memory to the first data beat
`define AVMM_RD_LATENCY 2
// Width of the counter that walks through the read latency
`define AVMM_RD_LAT_WIDTH 2

`endif
